/* rtl/adt7310Pkg.sv */
package adt7310Pkg;

  // SPI byte and sensor word widths.
  localparam int DataWidth = 8;
  localparam int WordWidth = 16;

  typedef logic [DataWidth-1:0] dataT;
  typedef logic [WordWidth-1:0] wordT;

  // SPI clock divider, in Clk_i cycles per SCLK half period.
  localparam int SpiClkHalf  = 2;
  localparam int DivCntWidth = $clog2(SpiClkHalf);
  localparam int BitCntWidth = $clog2(DataWidth);

  // Transmit and receive FIFO sizing.
  localparam int FifoDepth    = 4;
  localparam int FifoPtrWidth = 2;

  // ADT7310 command bytes.
  localparam dataT CmdWriteConfig = 8'h08;
  localparam dataT CmdOneShot     = 8'h20;  // Config value, one-shot mode.
  localparam dataT CmdReadTemp    = 8'h50;
  localparam dataT CmdDummy       = 8'hFF;

  typedef enum logic [3:0] {
    stIdle,
    stWriteValue,
    stWaitSent,
    stConsume1,
    stWait,
    stWriteDummy1,
    stWriteDummy2,
    stRead1,
    stRead2,
    stRead3,
    stPause
  } spiStateT;

  // Scheduler idle is stSIdle, since stIdle belongs to the sequencer.
  typedef enum logic [2:0] {
    stDisabled,
    stSIdle,
    stWaitTimer,
    stStart,
    stWaitDone,
    stCompare
  } sensorStateT;

  typedef enum logic {
    stMIdle,
    stMShift
  } masterStateT;

endpackage

/* rtl/spiMaster.sv */
`timescale 1ns/10ps

module spiMaster (
  input  logic             Clk_i,
  input  logic             SPI_FSM_TimerPreset,
  input  logic             Write_i,
  input  logic             ReadNext_i,
  input  adt7310Pkg::dataT Data_i,
  output adt7310Pkg::dataT Data_o,
  output logic             Transmission_o,
  output logic             FIFOFull_o,
  output logic             FIFOEmpty_o,
  output logic             SPI_SCLK_o,
  output logic             SPI_MOSI_o,
  input  logic             SPI_MISO_i
);
  import adt7310Pkg::*;

  dataT                    TxMem [FifoDepth];
  dataT                    RxMem [FifoDepth];
  logic [FifoPtrWidth-1:0] TxRd;
  logic [FifoPtrWidth-1:0] TxWr;
  logic [FifoPtrWidth-1:0] RxRd;
  logic [FifoPtrWidth-1:0] RxWr;
  logic [FifoPtrWidth:0]   TxCount;
  logic [FifoPtrWidth:0]   RxCount;
  logic                    TxPush;
  logic                    TxPop;
  logic                    RxPush;
  logic                    RxPop;

  masterStateT             State;
  logic [DivCntWidth-1:0]  DivCnt;
  logic [BitCntWidth-1:0]  BitCnt;
  dataT                    ShiftReg;
  dataT                    RxByte;
  logic                    Sclk;
  logic                    Mosi;
  logic                    HalfDone;
  logic                    ByteDone;

  assign HalfDone = (State == stMShift) && (DivCnt == DivCntWidth'(SpiClkHalf - 1));
  assign ByteDone = HalfDone && !Sclk && (BitCnt == BitCntWidth'(DataWidth - 1));
  assign RxByte   = {ShiftReg[DataWidth-2:0], SPI_MISO_i};

  // A full transmit FIFO drops the byte.
  assign TxPush = Write_i && (TxCount != FifoDepth);
  assign TxPop  = ((State == stMIdle) || ByteDone) && (TxCount != '0);
  assign RxPush = ByteDone && (RxCount != FifoDepth);
  assign RxPop  = ReadNext_i && (RxCount != '0);

  always_ff @(posedge Clk_i)
  begin
    if (TxPush)
    begin
      TxMem[TxWr] <= Data_i;
    end
    if (RxPush)
    begin
      RxMem[RxWr] <= RxByte;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      TxRd    <= '0;
      TxWr    <= '0;
      TxCount <= '0;
      RxRd    <= '0;
      RxWr    <= '0;
      RxCount <= '0;
    end
    else
    begin
      if (TxPush)
      begin
        TxWr <= TxWr + 1'b1;
      end
      if (TxPop)
      begin
        TxRd <= TxRd + 1'b1;
      end
      if (TxPush && !TxPop)
      begin
        TxCount <= TxCount + 1'b1;
      end
      else if (TxPop && !TxPush)
      begin
        TxCount <= TxCount - 1'b1;
      end
      if (RxPush)
      begin
        RxWr <= RxWr + 1'b1;
      end
      if (RxPop)
      begin
        RxRd <= RxRd + 1'b1;
      end
      if (RxPush && !RxPop)
      begin
        RxCount <= RxCount + 1'b1;
      end
      else if (RxPop && !RxPush)
      begin
        RxCount <= RxCount - 1'b1;
      end
    end
  end

  // Mode 3: MOSI moves on the falling edge, MISO is taken on the rising edge.
  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      State  <= stMIdle;
      DivCnt <= '0;
      BitCnt <= '0;
      Sclk   <= 1'b1;
      Mosi   <= 1'b1;
    end
    else if (State == stMIdle)
    begin
      if (TxPop)
      begin
        State  <= stMShift;
        DivCnt <= '0;
        BitCnt <= '0;
      end
    end
    else if (HalfDone)
    begin
      DivCnt <= '0;
      Sclk   <= !Sclk;
      if (Sclk)
      begin
        Mosi <= ShiftReg[DataWidth-1];
      end
      else
      begin
        BitCnt <= BitCnt + 1'b1;  // Wraps to zero for a back-to-back byte.
        if (ByteDone && !TxPop)
        begin
          State <= stMIdle;
        end
      end
    end
    else
    begin
      DivCnt <= DivCnt + 1'b1;
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (TxPop)
    begin
      ShiftReg <= TxMem[TxRd];
    end
    else if (HalfDone && !Sclk)
    begin
      ShiftReg <= RxByte;
    end
  end

  assign Transmission_o = (TxCount != '0) || (State == stMShift);
  assign Data_o         = RxMem[RxRd];  // Receive FIFO head.
  assign FIFOFull_o     = (RxCount == FifoDepth);
  assign FIFOEmpty_o    = (RxCount == '0);
  assign SPI_SCLK_o     = Sclk;
  assign SPI_MOSI_o     = Mosi;

endmodule

/* rtl/spiFsm.sv */
`timescale 1ns/10ps

module spiFsm (
  input  logic             Clk_i,
  input  logic             SPI_FSM_TimerPreset,
  input  logic             Start_i,
  output logic             Done_o,
  output adt7310Pkg::dataT Byte0_o,
  output adt7310Pkg::dataT Byte1_o,
  input  logic             SPI_Transmission_i,
  output logic             SPI_Write_o,
  output logic             SPI_ReadNext_o,
  output adt7310Pkg::dataT SPI_Data_o,
  input  adt7310Pkg::dataT SPI_Data_i,
  output logic             ADT7310CS_n_o,
  input  adt7310Pkg::wordT ParamCounterPreset_i
);
  import adt7310Pkg::*;

  spiStateT State;
  spiStateT NextState;
  wordT     Timer;
  logic     TimerLoad;
  logic     TimerEnable;
  logic     TimerOvfl;
  logic     WrByte1;
  logic     WrByte0;

  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      State <= stIdle;
    end
    else
    begin
      State <= NextState;
    end
  end

  always_comb
  begin
    NextState      = State;
    ADT7310CS_n_o  = 1'b1;
    SPI_Data_o     = CmdDummy;
    SPI_Write_o    = 1'b0;
    SPI_ReadNext_o = 1'b0;
    TimerLoad      = 1'b0;
    TimerEnable    = 1'b0;
    WrByte1        = 1'b0;
    WrByte0        = 1'b0;
    Done_o         = 1'b0;
    case (State)
      stIdle:
      begin
        Done_o = !Start_i;
        if (Start_i)
        begin
          NextState     = stWriteValue;
          ADT7310CS_n_o = 1'b0;
          SPI_Data_o    = CmdWriteConfig;
          SPI_Write_o   = 1'b1;
        end
      end
      stWriteValue:
      begin
        NextState     = stWaitSent;
        ADT7310CS_n_o = 1'b0;
        SPI_Data_o    = CmdOneShot;
        SPI_Write_o   = 1'b1;
      end
      stWaitSent:
      begin
        ADT7310CS_n_o = 1'b0;
        if (!SPI_Transmission_i)
        begin
          NextState      = stConsume1;
          SPI_ReadNext_o = 1'b1;  // Drop the reply to the command byte.
          TimerLoad      = 1'b1;
        end
      end
      // Chip select is released while the conversion runs.
      stConsume1:
      begin
        NextState      = stWait;
        SPI_ReadNext_o = 1'b1;
        TimerEnable    = 1'b1;
      end
      stWait:
      begin
        if (!TimerOvfl)
        begin
          TimerEnable = 1'b1;
        end
        else
        begin
          NextState     = stWriteDummy1;
          ADT7310CS_n_o = 1'b0;
          SPI_Data_o    = CmdReadTemp;
          SPI_Write_o   = 1'b1;
        end
      end
      stWriteDummy1:
      begin
        NextState     = stWriteDummy2;
        ADT7310CS_n_o = 1'b0;
        SPI_Write_o   = 1'b1;
      end
      stWriteDummy2:
      begin
        NextState     = stRead1;
        ADT7310CS_n_o = 1'b0;
        SPI_Write_o   = 1'b1;
      end
      stRead1:
      begin
        ADT7310CS_n_o = 1'b0;
        if (!SPI_Transmission_i)
        begin
          NextState      = stRead2;
          SPI_ReadNext_o = 1'b1;
        end
      end
      stRead2:
      begin
        NextState      = stRead3;
        SPI_ReadNext_o = 1'b1;
        WrByte1        = 1'b1;  // MSB.
      end
      stRead3:
      begin
        NextState      = stPause;
        SPI_ReadNext_o = 1'b1;
        WrByte0        = 1'b1;
      end
      stPause:
      begin
        NextState = stIdle;
      end
      default:
      begin
        NextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      Byte0_o <= '0;
      Byte1_o <= '0;
    end
    else
    begin
      if (WrByte0)
      begin
        Byte0_o <= SPI_Data_i;
      end
      if (WrByte1)
      begin
        Byte1_o <= SPI_Data_i;
      end
    end
  end

  // Conversion wait timer.
  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      Timer <= '0;
    end
    else if (TimerLoad)
    begin
      Timer <= ParamCounterPreset_i;
    end
    else if (TimerEnable)
    begin
      Timer <= Timer - 1'b1;
    end
  end

  assign TimerOvfl = (Timer == '0);

endmodule

/* rtl/sensorFsm.sv */
`timescale 1ns/10ps

module sensorFsm (
  input  logic             Clk_i,
  input  logic             SPI_FSM_TimerPreset,
  input  logic             Enable_i,
  input  adt7310Pkg::wordT PeriodPreset_i,
  input  adt7310Pkg::wordT Threshold_i,
  input  logic             Done_i,
  input  adt7310Pkg::dataT Byte0_i,
  input  adt7310Pkg::dataT Byte1_i,
  output logic             Start_o,
  output logic             CpuIntr_o,
  output adt7310Pkg::wordT SensorValue_o
);
  import adt7310Pkg::*;

  sensorStateT State;
  sensorStateT NextState;
  wordT        Timer;
  wordT        NewValue;
  wordT        Distance;
  logic        TimerLoad;
  logic        TimerEnable;
  logic        Exceeded;

  assign NewValue = {Byte1_i, Byte0_i};
  // Unsigned distance to the last reported value.
  assign Distance = (NewValue >= SensorValue_o) ? NewValue - SensorValue_o
                                                : SensorValue_o - NewValue;
  assign Exceeded = (Distance > Threshold_i);

  always_comb
  begin
    NextState   = State;
    TimerLoad   = 1'b0;
    TimerEnable = 1'b0;
    case (State)
      stDisabled:
      begin
        if (Enable_i)
        begin
          NextState = stSIdle;
          TimerLoad = 1'b1;
        end
      end
      stSIdle, stWaitTimer:
      begin
        if (!Enable_i)
        begin
          NextState = stDisabled;
        end
        else if (Timer == '0)
        begin
          NextState = stStart;
        end
        else
        begin
          NextState   = stWaitTimer;
          TimerEnable = 1'b1;
        end
      end
      stStart:    NextState = stWaitDone;
      stWaitDone:
      begin
        if (Done_i)
        begin
          NextState = stCompare;
        end
      end
      stCompare:
      begin
        NextState = stSIdle;
        TimerLoad = 1'b1;  // Period restarts here.
      end
      default:    NextState = stDisabled;
    endcase
  end

  always_ff @(posedge Clk_i)
  begin
    if (SPI_FSM_TimerPreset)
    begin
      State         <= stDisabled;
      Timer         <= '0;
      SensorValue_o <= '0;
      CpuIntr_o     <= 1'b0;
    end
    else
    begin
      State     <= NextState;
      CpuIntr_o <= 1'b0;
      if (TimerLoad)
      begin
        Timer <= PeriodPreset_i;
      end
      else if (TimerEnable)
      begin
        Timer <= Timer - 1'b1;
      end
      if ((State == stCompare) && Exceeded)
      begin
        SensorValue_o <= NewValue;
        CpuIntr_o     <= 1'b1;
      end
    end
  end

  assign Start_o = (State == stStart);

endmodule

/* rtl/adt7310Top.sv */
`timescale 1ns/10ps

module adt7310Top (
  input  logic             Clk_i,
  input  logic             SPI_FSM_TimerPreset,
  input  logic             Enable_i,
  input  adt7310Pkg::wordT PeriodPreset_i,
  input  adt7310Pkg::wordT Threshold_i,
  input  adt7310Pkg::wordT ParamCounterPreset_i,
  output logic             CpuIntr_o,
  output adt7310Pkg::wordT SensorValue_o,
  output logic             SPI_SCLK_o,
  output logic             SPI_MOSI_o,
  input  logic             SPI_MISO_i,
  output logic             ADT7310CS_n_o
);
  import adt7310Pkg::*;

  logic Start;
  logic Done;
  dataT Byte0;
  dataT Byte1;
  logic SpiWrite;
  logic SpiReadNext;
  logic SpiTransmission;
  dataT SpiTxData;
  dataT SpiRxData;

  sensorFsm SensorFsm (
    .Clk_i               (Clk_i),
    .SPI_FSM_TimerPreset (SPI_FSM_TimerPreset),
    .Enable_i            (Enable_i),
    .PeriodPreset_i      (PeriodPreset_i),
    .Threshold_i         (Threshold_i),
    .Done_i              (Done),
    .Byte0_i             (Byte0),
    .Byte1_i             (Byte1),
    .Start_o             (Start),
    .CpuIntr_o           (CpuIntr_o),
    .SensorValue_o       (SensorValue_o)
  );

  spiFsm SpiFsm (
    .Clk_i                (Clk_i),
    .SPI_FSM_TimerPreset  (SPI_FSM_TimerPreset),
    .Start_i              (Start),
    .Done_o               (Done),
    .Byte0_o              (Byte0),
    .Byte1_o              (Byte1),
    .SPI_Transmission_i   (SpiTransmission),
    .SPI_Write_o          (SpiWrite),
    .SPI_ReadNext_o       (SpiReadNext),
    .SPI_Data_o           (SpiTxData),
    .SPI_Data_i           (SpiRxData),
    .ADT7310CS_n_o        (ADT7310CS_n_o),
    .ParamCounterPreset_i (ParamCounterPreset_i)
  );

  // Receive FIFO flags are left open.
  spiMaster SpiMaster (
    .Clk_i               (Clk_i),
    .SPI_FSM_TimerPreset (SPI_FSM_TimerPreset),
    .Write_i             (SpiWrite),
    .ReadNext_i          (SpiReadNext),
    .Data_i              (SpiTxData),
    .Data_o              (SpiRxData),
    .Transmission_o      (SpiTransmission),
    .FIFOFull_o          (),
    .FIFOEmpty_o         (),
    .SPI_SCLK_o          (SPI_SCLK_o),
    .SPI_MOSI_o          (SPI_MOSI_o),
    .SPI_MISO_i          (SPI_MISO_i)
  );

endmodule

/* dv/adt7310_assertions.sv */
`timescale 1ns/10ps

module adt7310Assertions (
  input logic                              Clk_i,
  input logic                              Reset_i,
  input logic                              CsN_i,
  input logic                              Sclk_i,
  input logic                              Start_i,
  input logic                              Done_i,
  input logic                              CpuIntr_i,
  input logic                              TxWrite_i,
  input logic [adt7310Pkg::FifoPtrWidth:0] TxCount_i,
  input logic                              RxReadNext_i,
  input logic                              RxFull_i,
  input logic                              RxEmpty_i
);
  import adt7310Pkg::*;

  // A mode 3 frame opens with SCLK at its idle level.
  CsFallSclkHigh: assert property (@(posedge Clk_i) disable iff (Reset_i)
    $fell(CsN_i) |-> Sclk_i)
    else $error("Chip select fell while SCLK was low");

  StartOneCycle: assert property (@(posedge Clk_i) disable iff (Reset_i)
    Start_i |=> !Start_i)
    else $error("Start lasted more than one cycle");

  // Done drops in the cycle the sequencer takes Start.
  StartWhileDone: assert property (@(posedge Clk_i) disable iff (Reset_i)
    Start_i |-> $past(Done_i))
    else $error("Start issued while the sequencer was busy");

  IntrOneCycle: assert property (@(posedge Clk_i) disable iff (Reset_i)
    CpuIntr_i |=> !CpuIntr_i)
    else $error("Interrupt lasted two cycles");

  TxNoOverflow: assert property (@(posedge Clk_i) disable iff (Reset_i)
    TxWrite_i |-> (int'(TxCount_i) != FifoDepth))
    else $error("Transmit FIFO written while full");

  // The sequencer pops only bytes the shifter has delivered.
  RxNoUnderflow: assert property (@(posedge Clk_i) disable iff (Reset_i)
    RxReadNext_i |-> !RxEmpty_i)
    else $error("Receive FIFO read while empty");

  RxNeverFull: assert property (@(posedge Clk_i) disable iff (Reset_i)
    !RxFull_i)
    else $error("Receive FIFO filled up");

endmodule

// One instance in the top level sees the scheduler, the sequencer and the SPI master.
bind adt7310Top adt7310Assertions Assertions (
  .Clk_i        (Clk_i),
  .Reset_i      (SPI_FSM_TimerPreset),
  .CsN_i        (ADT7310CS_n_o),
  .Sclk_i       (SPI_SCLK_o),
  .Start_i      (Start),
  .Done_i       (Done),
  .CpuIntr_i    (CpuIntr_o),
  .TxWrite_i    (SpiWrite),
  .TxCount_i    (SpiMaster.TxCount),
  .RxReadNext_i (SpiReadNext),
  .RxFull_i     (SpiMaster.FIFOFull_o),
  .RxEmpty_i    (SpiMaster.FIFOEmpty_o)
);

/* dv/adt7310Tb.sv */
`timescale 1ns/10ps

module adt7310Tb;
  import adt7310Pkg::*;

  localparam int          ClkHalf       = 20;
  localparam int          Settle        = 2;    // Drive and sample point after the rising edge.
  localparam logic [31:0] Seed          = 32'h79ba_5455;
  localparam int          IntrWindow    = 10;
  localparam int          TimeoutMargin = 120;
  localparam dataT        ExpConfigCmd  = 8'h08;
  localparam dataT        ExpOneShot    = 8'h20;
  localparam dataT        ExpReadCmd    = 8'h50;
  localparam dataT        ExpDummy      = 8'hFF;

  logic Clk;
  logic SPI_FSM_TimerPreset;
  logic Enable;
  wordT PeriodPreset;
  wordT Threshold;
  wordT ParamCounterPreset;
  logic Miso;
  logic CpuIntr;
  wordT SensorValue;
  logic Sclk;
  logic Mosi;
  logic CsN;

  wordT stimTemp [$];
  logic stimEnable [$];
  int   cycleCount;
  int   cycleLimit;

  // Sensor model state.
  wordT tempWord;
  dataT frameBytes [$];
  dataT rxShift;
  dataT txShift;
  int   bitCnt;
  int   frameCount;
  int   readFrames;
  int   intrCount;
  int   csRiseCycle;
  logic csPrev;
  logic sclkPrev;

  adt7310Top UUT (
    .Clk_i                (Clk),
    .SPI_FSM_TimerPreset  (SPI_FSM_TimerPreset),
    .Enable_i             (Enable),
    .PeriodPreset_i       (PeriodPreset),
    .Threshold_i          (Threshold),
    .ParamCounterPreset_i (ParamCounterPreset),
    .CpuIntr_o            (CpuIntr),
    .SensorValue_o        (SensorValue),
    .SPI_SCLK_o           (Sclk),
    .SPI_MOSI_o           (Mosi),
    .SPI_MISO_i           (Miso),
    .ADT7310CS_n_o        (CsN)
  );

  always #ClkHalf Clk = !Clk;

  task automatic abortRun(input string msg);
  begin
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first error.");
  end
  endtask

  task automatic checkWord(input wordT got, input wordT exp, input string what);
  begin
    if (got !== exp)
    begin
      abortRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  end
  endtask

  task automatic checkByte(input dataT got, input dataT exp, input string what);
  begin
    if (got !== exp)
    begin
      abortRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
  begin
    if (got !== exp)
    begin
      abortRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  end
  endtask

  // Unsigned distance between two readings.
  function automatic wordT distance(input wordT a, input wordT b);
    int diff;
  begin
    diff = int'(a) - int'(b);
    if (diff < 0)
    begin
      diff = -diff;
    end
    return wordT'(diff);
  end
  endfunction

  // The read frame answers with the temperature word, MSB after the command byte.
  function automatic dataT nextReply();
  begin
    if ((frameBytes[0] == ExpReadCmd) && (frameBytes.size() == 1))
    begin
      return tempWord[15:8];
    end
    if ((frameBytes[0] == ExpReadCmd) && (frameBytes.size() == 2))
    begin
      return tempWord[7:0];
    end
    return dataT'($urandom);
  end
  endfunction

  task automatic readStim();
    int          fd;
    int          got;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic        haveHeader;
  begin
    haveHeader = 1'b0;
    fd = $fopen("dv/adt7310_stim.txt", "r");
    if (fd == 0)
    begin
      abortRun("Could not open the stimulus file dv/adt7310_stim.txt.");
    end
    while (!$feof(fd))
    begin
      got = $fgets(line, fd);
      if ((got > 0) && (line.len() > 0) && (line[0] != "/"))
      begin
        if (!haveHeader && ($sscanf(line, "%h %h %h", a, b, c) == 3))
        begin
          PeriodPreset       = a[15:0];
          ParamCounterPreset = b[15:0];
          Threshold          = c[15:0];
          haveHeader         = 1'b1;
        end
        else if (haveHeader && ($sscanf(line, "%h %h", a, b) == 2))
        begin
          stimTemp.push_back(a[15:0]);
          stimEnable.push_back(b[0]);
        end
      end
    end
    $fclose(fd);
    if (!haveHeader || (stimTemp.size() == 0))
    begin
      abortRun("The stimulus file holds no settings line or no measurement lines.");
    end
  end
  endtask

  task automatic checkFrame();
  begin
    if ((frameCount % 2) == 1)
    begin
      checkWord(wordT'(frameBytes.size()), 16'd2, "configuration frame length");
      checkByte(frameBytes[0], ExpConfigCmd, "configuration command byte");
      checkByte(frameBytes[1], ExpOneShot, "one-shot configuration value");
    end
    else
    begin
      checkWord(wordT'(frameBytes.size()), 16'd3, "read frame length");
      checkByte(frameBytes[0], ExpReadCmd, "read temperature command");
      checkByte(frameBytes[1], ExpDummy, "first dummy byte");
      checkByte(frameBytes[2], ExpDummy, "second dummy byte");
      readFrames++;
    end
  end
  endtask

  always @(posedge Clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      abortRun($sformatf("Timeout: no progress after %0d clock cycles.", cycleCount));
    end
  end

  // ADT7310 model as a mode 3 slave. Pins are sampled once per cycle after they settle.
  always
  begin
    @(posedge Clk);
    #Settle;
    if (!SPI_FSM_TimerPreset)
    begin
      if (CpuIntr)
      begin
        intrCount++;
      end
      if (csPrev && !CsN)
      begin
        frameCount++;
        bitCnt  = 0;
        frameBytes.delete();
        txShift = dataT'($urandom);
        // The conversion wait keeps chip select high before the read frame.
        if ((frameCount % 2) == 0)
        begin
          checkBit((cycleCount - csRiseCycle) >= int'(ParamCounterPreset), 1'b1,
                   "chip select gap covers conversion wait");
        end
      end
      if (!CsN && sclkPrev && !Sclk)
      begin
        Miso    = txShift[7];
        txShift = txShift << 1;
      end
      if (!CsN && !sclkPrev && Sclk)
      begin
        rxShift = {rxShift[6:0], Mosi};
        bitCnt++;
        if (bitCnt == 8)
        begin
          bitCnt = 0;
          frameBytes.push_back(rxShift);
          txShift = nextReply();
        end
      end
      if (!csPrev && CsN)
      begin
        csRiseCycle = cycleCount;
        checkFrame();
      end
    end
    csPrev   = CsN;
    sclkPrev = Sclk;
  end

  initial
  begin
    wordT lastValue;
    logic expIntr;
    int   framesSeen;
    int   intrSeen;
    int   readsSeen;
    Clk                 = 1'b0;
    SPI_FSM_TimerPreset = 1'b1;
    Enable              = 1'b0;
    PeriodPreset        = '0;
    Threshold           = '0;
    ParamCounterPreset  = '0;
    Miso                = 1'b1;
    cycleCount          = 0;
    cycleLimit          = 1000;
    tempWord            = '0;
    rxShift             = '0;
    txShift             = '0;
    bitCnt              = 0;
    frameCount          = 0;
    readFrames          = 0;
    intrCount           = 0;
    csRiseCycle         = 0;
    csPrev              = 1'b1;
    sclkPrev            = 1'b1;
    void'($urandom(Seed));
    readStim();
    cycleLimit = (stimTemp.size() + 1) *
                 (int'(PeriodPreset) + int'(ParamCounterPreset) + TimeoutMargin) * 2;

    repeat (4) @(posedge Clk);
    #Settle;
    SPI_FSM_TimerPreset = 1'b0;
    @(negedge Clk);
    checkBit(CsN, 1'b1, "chip select after reset");
    checkBit(Sclk, 1'b1, "SCLK after reset");
    checkBit(CpuIntr, 1'b0, "interrupt after reset");
    checkWord(SensorValue, 16'h0000, "sensor value after reset");

    lastValue = '0;
    for (int idx = 0; idx < stimTemp.size(); idx++)
    begin
      tempWord   = stimTemp[idx];
      framesSeen = frameCount;
      intrSeen   = intrCount;
      readsSeen  = readFrames;
      @(posedge Clk);
      #Settle;
      Enable = stimEnable[idx];
      if (stimEnable[idx])
      begin
        wait (readFrames == readsSeen + 1);
        repeat (IntrWindow) @(negedge Clk);  // The pulse comes a few cycles after chip select rises.
        expIntr = (distance(stimTemp[idx], lastValue) > Threshold);
        if (expIntr)
        begin
          lastValue = stimTemp[idx];
        end
        checkWord(wordT'(intrCount - intrSeen), wordT'(expIntr), "interrupt pulses");
        checkWord(SensorValue, lastValue, "reported sensor value");
      end
      else
      begin
        repeat (int'(PeriodPreset) + int'(ParamCounterPreset) + TimeoutMargin) @(negedge Clk);
        checkWord(wordT'(frameCount - framesSeen), 16'h0000, "frames while disabled");
        checkWord(wordT'(intrCount - intrSeen), 16'h0000, "interrupts while disabled");
      end
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* dv/adt7310_stim.txt */
// Settings line: PeriodPreset ParamCounterPreset Threshold, all hex.
// Measurement lines: temperature word (hex), Enable (0 or 1).
0014 001E 0010
0C80 1
0C88 1
0C98 1
0C98 0
0CA8 1
0CA9 1
0000 0
F380 1
F388 1
0CA9 1
0CA9 1
0C00 1
0C0F 1
0C20 1

/* build.f */
rtl/adt7310Pkg.sv
rtl/spiMaster.sv
rtl/spiFsm.sv
rtl/sensorFsm.sv
rtl/adt7310Top.sv
dv/adt7310_assertions.sv
dv/adt7310Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the ADT7310 reader testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module adt7310Tb -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

simOutput=$(./obj_dir/Vadt7310Tb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus."
  exit 1
fi

if echo "$simOutput" | grep -q "NO ERRORS"; then
  exit 0
fi
echo "Pass message not found in the simulation output."
exit 1
